// File: bedrock_pkg.sv
// Memory command and response message types shared by the tile and its testbench
package bedrock_pkg;

  // Physical address and data beat widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;

  typedef enum logic
  {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_t;

  // Single header per message, no size or length field
  typedef struct packed
  {
    mem_op_t             op;
    logic [ADDR_W-1:0]   addr;
  } mem_hdr_t;

  // Write data rides with the header in one beat
  typedef struct packed
  {
    mem_hdr_t            hdr;
    logic [DATA_W-1:0]   data;
  } mem_cmd_t;

  // Header is echoed back unchanged
  typedef struct packed
  {
    mem_hdr_t            hdr;
    logic [DATA_W-1:0]   data;
  } mem_resp_t;

endpackage

// File: tile_cfg_pkg.sv
// Tile address map, device selectors and configuration bus layout, used by RTL and testbench
package tile_cfg_pkg;

  // Addresses at or above this are off-tile memory
  localparam logic [bedrock_pkg::ADDR_W-1:0] DRAM_BASE = 32'h8000_0000;

  // Device field of a local address
  localparam int DEV_LSB = 16;
  localparam int DEV_W   = 4;
  localparam logic [DEV_W-1:0] CFG_DEV   = 4'd2;
  localparam logic [DEV_W-1:0] CACHE_DEV = 4'd5;

  // Register index sits above the dword offset
  localparam int REG_LSB = 3;

  localparam int NUM_DEV = 3;

  typedef enum logic [1:0]
  {
    DEV_MEM  = 2'd0,
    DEV_CFG  = 2'd1,
    DEV_LOOP = 2'd2
  } dev_sel_t;

  typedef enum logic [4:0]
  {
    REG_FREEZE  = 5'd0,
    REG_CORE_ID = 5'd1,
    REG_DID     = 5'd2,
    REG_CORD    = 5'd3
  } cfg_reg_e;

  typedef struct packed
  {
    logic         freeze;
    logic [7:0]   core_id;
    logic [7:0]   did;
    logic [15:0]  cord;
  } cfg_bus_t;

endpackage

// File: msg_fifo.sv
// Two-entry valid/ready-and FIFO for any packed message, used at both tile boundaries
`timescale 1ns/1ps

module msg_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_and_o,

  output logic     v_o,
  output payload_t data_o,
  input  logic     ready_and_i
);

  payload_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign ready_and_o = (count_q != 2'd2);
  assign v_o         = (count_q != 2'd0);
  assign data_o      = mem_q[rd_ptr_q];

  assign push = v_i & ready_and_o;
  assign pop  = v_v_unused_guard();

  function automatic logic v_v_unused_guard();
    return v_o & ready_and_i;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ~wr_ptr_q;
      if (pop)
        rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= data_i;
  end

  // Occupancy never passes the two entries
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q != 2'd3);

  // Sender must hold its message while stalled
  a_hold_input: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (v_i && !ready_and_o) |=> (v_i && $stable(data_i)));

endmodule

// File: dev_xbar.sv
// Routes tile commands to the memory, config and loopback devices and merges responses in order
`timescale 1ns/1ps

module dev_xbar #(
  parameter int ORDER_DEPTH = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,

  input  logic                                         cmd_v_i,
  input  bedrock_pkg::mem_cmd_t                        cmd_i,
  output logic                                         cmd_ready_and_o,

  output logic [tile_cfg_pkg::NUM_DEV-1:0]             dev_cmd_v_o,
  output bedrock_pkg::mem_cmd_t                        dev_cmd_o,
  input  logic [tile_cfg_pkg::NUM_DEV-1:0]             dev_cmd_ready_and_i,

  input  logic [tile_cfg_pkg::NUM_DEV-1:0]             dev_resp_v_i,
  input  bedrock_pkg::mem_resp_t [tile_cfg_pkg::NUM_DEV-1:0] dev_resp_i,
  output logic [tile_cfg_pkg::NUM_DEV-1:0]             dev_resp_ready_and_o,

  output logic                                         resp_v_o,
  output bedrock_pkg::mem_resp_t                       resp_o,
  input  logic                                         resp_ready_and_i
);

  localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

  logic                              is_local;
  logic [tile_cfg_pkg::DEV_W-1:0]    dev_field;
  tile_cfg_pkg::dev_sel_t            dst;
  tile_cfg_pkg::dev_sel_t            order_q [ORDER_DEPTH];
  tile_cfg_pkg::dev_sel_t            head;
  logic [PTR_W-1:0]                  wr_ptr_q;
  logic [PTR_W-1:0]                  rd_ptr_q;
  logic [CNT_W-1:0]                  count_q;
  logic                              q_full;
  logic                              q_empty;
  logic                              push;
  logic                              pop;

  // Address decode
  assign is_local  = (cmd_i.hdr.addr < tile_cfg_pkg::DRAM_BASE);
  assign dev_field = cmd_i.hdr.addr[tile_cfg_pkg::DEV_LSB +: tile_cfg_pkg::DEV_W];

  always_comb
  begin
    if (!is_local || (dev_field == tile_cfg_pkg::CACHE_DEV))
      dst = tile_cfg_pkg::DEV_MEM;
    else if (dev_field == tile_cfg_pkg::CFG_DEV)
      dst = tile_cfg_pkg::DEV_CFG;
    else
      dst = tile_cfg_pkg::DEV_LOOP;
  end

  assign q_full  = (count_q == CNT_W'(ORDER_DEPTH));
  assign q_empty = (count_q == '0);
  assign head    = order_q[rd_ptr_q];

  // Payload is broadcast to all devices
  assign dev_cmd_o       = cmd_i;
  assign dev_cmd_v_o     = (cmd_v_i && !q_full) ? (3'b001 << dst) : 3'b000;
  assign cmd_ready_and_o = !q_full && dev_cmd_ready_and_i[dst];
  assign push            = cmd_v_i && cmd_ready_and_o;

  // Only the oldest outstanding device may answer
  assign resp_v_o             = !q_empty && dev_resp_v_i[head];
  assign resp_o               = dev_resp_i[head];
  assign dev_resp_ready_and_o = !q_empty ? ({2'b00, resp_ready_and_i} << head) : 3'b000;
  assign pop                  = resp_v_o && resp_ready_and_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      order_q[wr_ptr_q] <= dst;
  end

  // Every pending device response still has its entry in the order queue
  a_resp_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(dev_resp_v_i) <= int'(count_q));

endmodule

// File: cfg_regs.sv
// Configuration register slice, answers memory commands and drives the tile configuration bus
`timescale 1ns/1ps

module cfg_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   cmd_v_i,
  input  bedrock_pkg::mem_cmd_t  cmd_i,
  output logic                   cmd_ready_and_o,

  output logic                   resp_v_o,
  output bedrock_pkg::mem_resp_t resp_o,
  input  logic                   resp_ready_and_i,

  output tile_cfg_pkg::cfg_bus_t cfg_bus_o
);

  tile_cfg_pkg::cfg_bus_t            cfg_q;
  logic [4:0]                        reg_idx;
  logic [bedrock_pkg::DATA_W-1:0]    rd_data;
  logic                              is_wr;
  logic                              cmd_xfer;
  logic                              resp_v_q;
  bedrock_pkg::mem_resp_t            resp_q;

  assign reg_idx  = cmd_i.hdr.addr[tile_cfg_pkg::REG_LSB +: 5];
  assign is_wr    = (cmd_i.hdr.op == bedrock_pkg::MEM_WR);
  assign cmd_xfer = cmd_v_i && cmd_ready_and_o;

  // One response in flight at most
  assign cmd_ready_and_o = !resp_v_q;
  assign resp_v_o        = resp_v_q;
  assign resp_o          = resp_q;
  assign cfg_bus_o       = cfg_q;

  always_comb
  begin
    rd_data = '0;
    case (reg_idx)
      tile_cfg_pkg::REG_FREEZE:  rd_data[0]    = cfg_q.freeze;
      tile_cfg_pkg::REG_CORE_ID: rd_data[7:0]  = cfg_q.core_id;
      tile_cfg_pkg::REG_DID:     rd_data[7:0]  = cfg_q.did;
      tile_cfg_pkg::REG_CORD:    rd_data[15:0] = cfg_q.cord;
      default:                   rd_data       = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cfg_q    <= '{freeze: 1'b1, default: '0};
      resp_v_q <= 1'b0;
    end
    else
    begin
      if (cmd_xfer)
        resp_v_q <= 1'b1;
      else if (resp_ready_and_i)
        resp_v_q <= 1'b0;

      if (cmd_xfer && is_wr)
      begin
        case (reg_idx)
          tile_cfg_pkg::REG_FREEZE:  cfg_q.freeze  <= cmd_i.data[0];
          tile_cfg_pkg::REG_CORE_ID: cfg_q.core_id <= cmd_i.data[7:0];
          tile_cfg_pkg::REG_DID:     cfg_q.did     <= cmd_i.data[7:0];
          tile_cfg_pkg::REG_CORD:    cfg_q.cord    <= cmd_i.data[15:0];
          default:                   cfg_q         <= cfg_q;
        endcase
      end
    end
  end

  // Write acks carry no data
  always_ff @(posedge clk_i)
  begin
    if (cmd_xfer)
    begin
      resp_q.hdr  <= cmd_i.hdr;
      resp_q.data <= is_wr ? '0 : rd_data;
    end
  end

endmodule

// File: loopback_dev.sv
// Target for unmapped local devices, acks writes and returns zero on reads
`timescale 1ns/1ps

module loopback_dev (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   cmd_v_i,
  input  bedrock_pkg::mem_cmd_t  cmd_i,
  output logic                   cmd_ready_and_o,

  output logic                   resp_v_o,
  output bedrock_pkg::mem_resp_t resp_o,
  input  logic                   resp_ready_and_i
);

  logic                   resp_v_q;
  bedrock_pkg::mem_hdr_t  hdr_q;

  assign cmd_ready_and_o = !resp_v_q;
  assign resp_v_o        = resp_v_q;
  assign resp_o.hdr      = hdr_q;
  assign resp_o.data     = '0;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_q <= 1'b0;
    else if (cmd_v_i && cmd_ready_and_o)
      resp_v_q <= 1'b1;
    else if (resp_ready_and_i)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i && cmd_ready_and_o)
      hdr_q <= cmd_i.hdr;
  end

endmodule

// File: mem_store.sv
// Word-addressed memory device standing in for the L2 slice, fixed two-cycle response
`timescale 1ns/1ps

module mem_store #(
  parameter int MEM_WORDS = 64
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   cmd_v_i,
  input  bedrock_pkg::mem_cmd_t  cmd_i,
  output logic                   cmd_ready_and_o,

  output logic                   resp_v_o,
  output bedrock_pkg::mem_resp_t resp_o,
  input  logic                   resp_ready_and_i
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [bedrock_pkg::DATA_W-1:0] mem_q [MEM_WORDS];
  logic [IDX_W-1:0]               cmd_idx;
  logic [IDX_W-1:0]               s1_idx_q;
  bedrock_pkg::mem_hdr_t          s1_hdr_q;
  logic                           s1_v_q;
  logic                           resp_v_q;
  bedrock_pkg::mem_resp_t         resp_q;
  logic                           cmd_xfer;

  assign cmd_idx  = IDX_W'(cmd_i.hdr.addr[bedrock_pkg::ADDR_W-1:3] % MEM_WORDS);
  assign cmd_xfer = cmd_v_i && cmd_ready_and_o;

  assign cmd_ready_and_o = !s1_v_q && !resp_v_q;
  assign resp_v_o        = resp_v_q;
  assign resp_o          = resp_q;

  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem_q[i] = '0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      s1_v_q   <= 1'b0;
      resp_v_q <= 1'b0;
    end
    else
    begin
      s1_v_q <= cmd_xfer;
      if (s1_v_q)
        resp_v_q <= 1'b1;
      else if (resp_ready_and_i)
        resp_v_q <= 1'b0;
    end
  end

  // Stage 1 latches the address, stage 2 reads the array
  always_ff @(posedge clk_i)
  begin
    if (cmd_xfer)
    begin
      s1_idx_q <= cmd_idx;
      s1_hdr_q <= cmd_i.hdr;
      if (cmd_i.hdr.op == bedrock_pkg::MEM_WR)
        mem_q[cmd_idx] <= cmd_i.data;
    end
    if (s1_v_q)
    begin
      resp_q.hdr  <= s1_hdr_q;
      resp_q.data <= (s1_hdr_q.op == bedrock_pkg::MEM_RD) ? mem_q[s1_idx_q] : '0;
    end
  end

  a_two_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_xfer |-> ##2 resp_v_o);

endmodule

// File: l2e_tile.sv
// L2-extension tile top, buffers the command and response streams around the device crossbar
`timescale 1ns/1ps

module l2e_tile #(
  parameter int MEM_WORDS   = 64,
  parameter int ORDER_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   cmd_v_i,
  input  bedrock_pkg::mem_cmd_t  cmd_i,
  output logic                   cmd_ready_and_o,

  output logic                   resp_v_o,
  output bedrock_pkg::mem_resp_t resp_o,
  input  logic                   resp_ready_and_i,

  output tile_cfg_pkg::cfg_bus_t cfg_bus_o
);

  logic                                               xcmd_v;
  bedrock_pkg::mem_cmd_t                              xcmd;
  logic                                               xcmd_ready_and;
  logic                                               xresp_v;
  bedrock_pkg::mem_resp_t                             xresp;
  logic                                               xresp_ready_and;

  // Device links indexed by dev_sel_t
  logic [tile_cfg_pkg::NUM_DEV-1:0]                   dev_cmd_v;
  bedrock_pkg::mem_cmd_t                              dev_cmd;
  logic [tile_cfg_pkg::NUM_DEV-1:0]                   dev_cmd_ready_and;
  logic [tile_cfg_pkg::NUM_DEV-1:0]                   dev_resp_v;
  bedrock_pkg::mem_resp_t [tile_cfg_pkg::NUM_DEV-1:0] dev_resp;
  logic [tile_cfg_pkg::NUM_DEV-1:0]                   dev_resp_ready_and;

  msg_fifo #(.payload_t(bedrock_pkg::mem_cmd_t)) u_cmd_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .v_i(cmd_v_i), .data_i(cmd_i), .ready_and_o(cmd_ready_and_o),
    .v_o(xcmd_v), .data_o(xcmd), .ready_and_i(xcmd_ready_and)
  );

  dev_xbar #(.ORDER_DEPTH(ORDER_DEPTH)) u_xbar (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_v_i(xcmd_v), .cmd_i(xcmd), .cmd_ready_and_o(xcmd_ready_and),
    .dev_cmd_v_o(dev_cmd_v), .dev_cmd_o(dev_cmd), .dev_cmd_ready_and_i(dev_cmd_ready_and),
    .dev_resp_v_i(dev_resp_v), .dev_resp_i(dev_resp), .dev_resp_ready_and_o(dev_resp_ready_and),
    .resp_v_o(xresp_v), .resp_o(xresp), .resp_ready_and_i(xresp_ready_and)
  );

  mem_store #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_v_i(dev_cmd_v[tile_cfg_pkg::DEV_MEM]), .cmd_i(dev_cmd),
    .cmd_ready_and_o(dev_cmd_ready_and[tile_cfg_pkg::DEV_MEM]),
    .resp_v_o(dev_resp_v[tile_cfg_pkg::DEV_MEM]), .resp_o(dev_resp[tile_cfg_pkg::DEV_MEM]),
    .resp_ready_and_i(dev_resp_ready_and[tile_cfg_pkg::DEV_MEM])
  );

  cfg_regs u_cfg (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_v_i(dev_cmd_v[tile_cfg_pkg::DEV_CFG]), .cmd_i(dev_cmd),
    .cmd_ready_and_o(dev_cmd_ready_and[tile_cfg_pkg::DEV_CFG]),
    .resp_v_o(dev_resp_v[tile_cfg_pkg::DEV_CFG]), .resp_o(dev_resp[tile_cfg_pkg::DEV_CFG]),
    .resp_ready_and_i(dev_resp_ready_and[tile_cfg_pkg::DEV_CFG]),
    .cfg_bus_o(cfg_bus_o)
  );

  loopback_dev u_loop (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_v_i(dev_cmd_v[tile_cfg_pkg::DEV_LOOP]), .cmd_i(dev_cmd),
    .cmd_ready_and_o(dev_cmd_ready_and[tile_cfg_pkg::DEV_LOOP]),
    .resp_v_o(dev_resp_v[tile_cfg_pkg::DEV_LOOP]), .resp_o(dev_resp[tile_cfg_pkg::DEV_LOOP]),
    .resp_ready_and_i(dev_resp_ready_and[tile_cfg_pkg::DEV_LOOP])
  );

  msg_fifo #(.payload_t(bedrock_pkg::mem_resp_t)) u_resp_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .v_i(xresp_v), .data_i(xresp), .ready_and_o(xresp_ready_and),
    .v_o(resp_v_o), .data_o(resp_o), .ready_and_i(resp_ready_and_i)
  );

endmodule

// File: tb_top.sv
// Random-stimulus testbench for the L2-extension tile, checks responses against a reference model
`timescale 1ns/1ps

module tb_top;

  localparam int MEM_WORDS   = 64;
  localparam int ORDER_DEPTH = 4;
  localparam int CMD_WAIT    = 500;
  localparam int DRAIN_WAIT  = 5000;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   cmd_v_i;
  bedrock_pkg::mem_cmd_t  cmd_i;
  logic                   cmd_ready_and_o;
  logic                   resp_v_o;
  bedrock_pkg::mem_resp_t resp_o;
  logic                   resp_ready_and_i;
  tile_cfg_pkg::cfg_bus_t cfg_bus_o;

  // Reference model state
  logic [63:0]            model_mem [MEM_WORDS];
  tile_cfg_pkg::cfg_bus_t model_cfg;
  bedrock_pkg::mem_resp_t exp_q [$];
  bedrock_pkg::mem_resp_t mon_exp;

  logic [31:0]            stim_state;
  logic [31:0]            bp_state;
  logic                   bp_on;

  l2e_tile #(.MEM_WORDS(MEM_WORDS), .ORDER_DEPTH(ORDER_DEPTH)) DUT (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_v_i(cmd_v_i), .cmd_i(cmd_i), .cmd_ready_and_o(cmd_ready_and_o),
    .resp_v_o(resp_v_o), .resp_o(resp_o), .resp_ready_and_i(resp_ready_and_i),
    .cfg_bus_o(cfg_bus_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  task automatic stop_failed();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_resp(input bedrock_pkg::mem_resp_t act, input bedrock_pkg::mem_resp_t exp);
    if (act !== exp)
    begin
      $display("ERR %0t resp_o: got %h expected %h", $time, act, exp);
      stop_failed();
    end
  endtask

  task automatic check_cfg(input tile_cfg_pkg::cfg_bus_t act, input tile_cfg_pkg::cfg_bus_t exp);
    if (act !== exp)
    begin
      $display("ERR %0t cfg_bus_o: got %h expected %h", $time, act, exp);
      stop_failed();
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("ERR %0t %s: got %b expected %b", $time, name, act, exp);
      stop_failed();
    end
  endtask

  // Kind 0 off-tile memory, 1 cache device, 2 config slice, other loopback
  function automatic bedrock_pkg::mem_cmd_t make_cmd(input int kind);
    bedrock_pkg::mem_cmd_t c;
    logic [31:0]           a;
    logic [31:0]           r;
    r = stim_rand();
    a = stim_rand();
    case (kind)
      0: a[31] = 1'b1;
      1:
      begin
        a[31]    = 1'b0;
        a[19:16] = tile_cfg_pkg::CACHE_DEV;
      end
      2:
      begin
        a[31]    = 1'b0;
        a[19:16] = tile_cfg_pkg::CFG_DEV;
        // Register index 0..7 where half are unmapped
        a[7:6]   = 2'b00;
      end
      default:
      begin
        a[31] = 1'b0;
        if (a[19:16] == tile_cfg_pkg::CFG_DEV || a[19:16] == tile_cfg_pkg::CACHE_DEV)
          a[19] = 1'b1;
      end
    endcase
    c.hdr.op   = r[0] ? bedrock_pkg::MEM_WR : bedrock_pkg::MEM_RD;
    c.hdr.addr = a;
    c.data     = {stim_rand(), stim_rand()};
    return c;
  endfunction

  // Expected response computed in command order
  task automatic apply_model(input bedrock_pkg::mem_cmd_t c);
    bedrock_pkg::mem_resp_t r;
    logic [3:0]             dev;
    logic [4:0]             idx;
    int unsigned            widx;
    logic                   is_wr;
    r.hdr  = c.hdr;
    r.data = '0;
    dev    = c.hdr.addr[19:16];
    idx    = c.hdr.addr[7:3];
    is_wr  = (c.hdr.op == bedrock_pkg::MEM_WR);
    if (c.hdr.addr >= tile_cfg_pkg::DRAM_BASE || dev == tile_cfg_pkg::CACHE_DEV)
    begin
      widx = (c.hdr.addr >> 3) % MEM_WORDS;
      if (is_wr)
        model_mem[widx] = c.data;
      else
        r.data = model_mem[widx];
    end
    else if (dev == tile_cfg_pkg::CFG_DEV)
    begin
      case (idx)
        5'd0:
          if (is_wr)
            model_cfg.freeze = c.data[0];
          else
            r.data = 64'(model_cfg.freeze);
        5'd1:
          if (is_wr)
            model_cfg.core_id = c.data[7:0];
          else
            r.data = 64'(model_cfg.core_id);
        5'd2:
          if (is_wr)
            model_cfg.did = c.data[7:0];
          else
            r.data = 64'(model_cfg.did);
        5'd3:
          if (is_wr)
            model_cfg.cord = c.data[15:0];
          else
            r.data = 64'(model_cfg.cord);
        default: r.data = '0;
      endcase
    end
    exp_q.push_back(r);
  endtask

  // Called 5 ns after a rising edge, returns 5 ns after the accepting edge
  task automatic send_cmd(input bedrock_pkg::mem_cmd_t c);
    int waited;
    waited  = 0;
    cmd_v_i = 1'b1;
    cmd_i   = c;
    @(negedge clk_i);
    while (!cmd_ready_and_o)
    begin
      waited++;
      if (waited > CMD_WAIT)
      begin
        $display("Timeout at %0t: tile never accepted command %h", $time, c);
        stop_failed();
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #5;
    cmd_v_i = 1'b0;
  endtask

  // Returns 5 ns after a rising edge once every response is in
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0)
    begin
      waited++;
      if (waited > DRAIN_WAIT)
      begin
        $display("Timeout at %0t: %0d responses never arrived", $time, exp_q.size());
        stop_failed();
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #5;
  endtask

  // Outputs only change at rising edges, so the falling edge sees settled values
  always @(negedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (cmd_v_i && cmd_ready_and_o)
        apply_model(cmd_i);
      if (resp_v_o && resp_ready_and_i)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Response at %0t with no command outstanding", $time);
          stop_failed();
        end
        else
        begin
          mon_exp = exp_q.pop_front();
          check_resp(resp_o, mon_exp);
        end
      end
    end
  end

  // Response back-pressure drops ready on about 30% of cycles when enabled
  always @(posedge clk_i)
  begin
    #5;
    bp_state = xorshift32(bp_state);
    if (bp_on)
      resp_ready_and_i = (bp_state[7:0] >= 8'd77);
    else
      resp_ready_and_i = 1'b1;
  end

  initial
  begin
    bedrock_pkg::mem_cmd_t c;
    logic [31:0]           r;
    int                    kind;
    stim_state       = 32'ha01f_7b94;
    bp_state         = xorshift32(32'ha01f_7b94 ^ 32'h5555_aaaa);
    bp_on            = 1'b0;
    rst_n_i          = 1'b0;
    cmd_v_i          = 1'b0;
    cmd_i            = '0;
    resp_ready_and_i = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++)
      model_mem[i] = '0;
    model_cfg         = '0;
    model_cfg.freeze  = 1'b1;

    repeat (2) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_cfg(cfg_bus_o, model_cfg);
    check_bit("resp_v_o", resp_v_o, 1'b0);
    check_bit("cmd_ready_and_o", cmd_ready_and_o, 1'b1);
    @(posedge clk_i);
    #5;

    // Memory through both routes
    for (int i = 0; i < 40; i++)
    begin
      r    = stim_rand();
      kind = int'(r[0]);
      send_cmd(make_cmd(kind));
    end
    wait_drain();

    // Config registers at known and unknown indices
    for (int i = 0; i < 8; i++)
    begin
      c.hdr.op             = bedrock_pkg::MEM_WR;
      c.hdr.addr           = '0;
      c.hdr.addr[19:16]    = tile_cfg_pkg::CFG_DEV;
      c.hdr.addr[7:3]      = 5'(i);
      c.data               = {stim_rand(), stim_rand()};
      send_cmd(c);
      wait_drain();
      check_cfg(cfg_bus_o, model_cfg);
      c.hdr.op = bedrock_pkg::MEM_RD;
      send_cmd(c);
      wait_drain();
    end

    for (int i = 0; i < 20; i++)
      send_cmd(make_cmd(3));
    wait_drain();

    // Interleaved traffic under back-pressure
    bp_on = 1'b1;
    for (int i = 0; i < 300; i++)
    begin
      r    = stim_rand();
      kind = int'(r[1:0]);
      send_cmd(make_cmd(kind));
      if (r[4:2] == 3'd0)
      begin
        @(posedge clk_i);
        #5;
      end
    end
    wait_drain();
    check_cfg(cfg_bus_o, model_cfg);

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: tb.f
bedrock_pkg.sv
tile_cfg_pkg.sv
msg_fifo.sv
dev_xbar.sv
cfg_regs.sv
loopback_dev.sv
mem_store.sv
l2e_tile.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# Build the tile testbench with Verilator and run it; exit status is the simulator's

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi
exit $status
